/* hdl/nnSettings.svh */
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

////////////////////////////////////////
// Network dimensions
////////////////////////////////////////

// Activations, weights and biases share one signed width
`define NN_WIDTH 8

// Features per input vector
`define NN_INPUTS 10

// Neurons in the hidden layer
`define NN_HIDDEN 4

// Output scores, one per class
`define NN_OUTPUTS 2

`endif

/* hdl/nnPkg.sv */
`default_nettype none

`include "nnSettings.svh"

package nnPkg;

	////////////////////////////////////////
	// Data types
	////////////////////////////////////////

	typedef logic signed [`NN_WIDTH-1:0] activation_t;

	// One bit is enough for two classes
	typedef logic [0:0] classIndex_t;

	typedef struct packed
	{
		activation_t a0;
		activation_t a1;
		activation_t a2;
		activation_t a3;
		activation_t a4;
		activation_t a5;
		activation_t a6;
		activation_t a7;
		activation_t a8;
		activation_t a9;
	} inputVec_t;

	typedef struct packed
	{
		activation_t h0;
		activation_t h1;
		activation_t h2;
		activation_t h3;
	} hiddenVec_t;

	typedef struct packed
	{
		activation_t s0;
		activation_t s1;
	} scoreVec_t;

	////////////////////////////////////////
	// Fixed weights and biases
	////////////////////////////////////////

	// One row per hidden neuron, one column per input feature
	localparam activation_t hiddenWeights [`NN_HIDDEN][`NN_INPUTS] = '{
		'{8'sh2E, 8'sh5D, 8'sh35, 8'sh32, 8'shF0,
			8'sh9A, 8'sh0A, 8'sh46, 8'shA4, 8'shEF},
		'{8'shE3, 8'sh17, 8'shC8, 8'sh0B, 8'sh3C,
			8'sh21, 8'shF6, 8'sh52, 8'sh09, 8'shB5},
		'{8'sh11, 8'shD4, 8'sh27, 8'sh7A, 8'sh05,
			8'shE8, 8'sh33, 8'shCE, 8'sh14, 8'sh2A},
		'{8'shF9, 8'sh41, 8'sh0C, 8'shDD, 8'sh58,
			8'sh13, 8'shAB, 8'sh06, 8'sh3F, 8'shE1}
	};

	localparam activation_t hiddenBias [`NN_HIDDEN] = '{
		8'sd7, -8'sd3, 8'sd12, -8'sd5
	};

	// One row per class, one column per hidden activation
	localparam activation_t outputWeights [`NN_OUTPUTS][`NN_HIDDEN] = '{
		'{8'sh1A, 8'shE6, 8'sh0F, 8'sh22},
		'{8'shF3, 8'sh19, 8'sh2B, 8'shEA}
	};

	localparam activation_t outputBias [`NN_OUTPUTS] = '{
		8'sd4, 8'sd2
	};

endpackage

`default_nettype wire

/* hdl/neuronNode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nnSettings.svh"

module neuronNode
	import nnPkg::*;
#(
	parameter int FANIN = `NN_INPUTS
)
(
	input  logic        clk,
	input  logic        reset,
	input  activation_t activations [FANIN],
	input  activation_t weights [FANIN],
	input  activation_t bias,
	output activation_t activation
);

	activation_t activationReg [FANIN];
	activation_t productSum;
	activation_t sumReg;

	////////////////////////////////////////
	// Weighted sum, wraps at 8 bits
	////////////////////////////////////////

	always_comb
	begin
		productSum = bias;
		for (int i = 0; i < FANIN; i++)
		begin
			// Only the low byte of each product is kept
			productSum = activation_t'(productSum
				+ activation_t'(activationReg[i] * weights[i]));
		end
	end

	////////////////////////////////////////
	// Input, sum and ReLU registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activationReg <= '{default: '0};
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			activationReg <= activations;
			sumReg <= productSum;

			// Negative sums clamp to zero
			if (sumReg[`NN_WIDTH-1])
			begin
				activation <= '0;
			end
			else
			begin
				activation <= sumReg;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/hiddenLayer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nnSettings.svh"

module hiddenLayer
	import nnPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  inputVec_t  inputs,
	input  logic       inValid,
	output hiddenVec_t hidden,
	output logic       hiddenValid
);

	activation_t inputArray [`NN_INPUTS];
	activation_t hiddenArray [`NN_HIDDEN];
	logic [2:0] validPipe;

	// Struct fields in feature order
	assign inputArray = '{inputs.a0, inputs.a1, inputs.a2, inputs.a3, inputs.a4,
		inputs.a5, inputs.a6, inputs.a7, inputs.a8, inputs.a9};

	for (genvar k = 0; k < `NN_HIDDEN; k++)
	begin : gNeuron
		neuronNode #(
			.FANIN(`NN_INPUTS)
		) node (
			.clk(clk),
			.reset(reset),
			.activations(inputArray),
			.weights(hiddenWeights[k]),
			.bias(hiddenBias[k]),
			.activation(hiddenArray[k])
		);
	end

	assign hidden = '{hiddenArray[0], hiddenArray[1], hiddenArray[2], hiddenArray[3]};

	// Valid follows the three neuron stages
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], inValid};
		end
	end

	assign hiddenValid = validPipe[2];

endmodule

`default_nettype wire

/* hdl/outputLayer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nnSettings.svh"

module outputLayer
	import nnPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  hiddenVec_t hidden,
	input  logic       hiddenValid,
	output scoreVec_t  scoreRaw,
	output logic       scoreValid
);

	activation_t hiddenArray [`NN_HIDDEN];
	activation_t scoreArray [`NN_OUTPUTS];
	logic [2:0] validPipe;

	assign hiddenArray = '{hidden.h0, hidden.h1, hidden.h2, hidden.h3};

	////////////////////////////////////////
	// One neuron per class
	////////////////////////////////////////

	for (genvar k = 0; k < `NN_OUTPUTS; k++)
	begin : gNeuron
		neuronNode #(
			.FANIN(`NN_HIDDEN)
		) node (
			.clk(clk),
			.reset(reset),
			.activations(hiddenArray),
			.weights(outputWeights[k]),
			.bias(outputBias[k]),
			.activation(scoreArray[k])
		);
	end

	assign scoreRaw = '{scoreArray[0], scoreArray[1]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], hiddenValid};
		end
	end

	assign scoreValid = validPipe[2];

endmodule

`default_nettype wire

/* hdl/classDecide.sv */
`timescale 1ns/1ps
`default_nettype none

module classDecide
	import nnPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  scoreVec_t   scoreRaw,
	input  logic        scoreValid,
	output scoreVec_t   scores,
	output classIndex_t classIndex,
	output logic        outValid
);

	logic secondWins;

	// Scores come out of ReLU so an unsigned compare is enough
	// Ties go to class 0
	assign secondWins = $unsigned(scoreRaw.s1) > $unsigned(scoreRaw.s0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scores <= '0;
			classIndex <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			scores <= scoreRaw;
			classIndex <= classIndex_t'(secondWins);
			outValid <= scoreValid;
		end
	end

endmodule

`default_nettype wire

/* hdl/nnClassifier.sv */
`timescale 1ns/1ps
`default_nettype none

module nnClassifier
	import nnPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  inputVec_t   inputs,
	input  logic        inValid,
	output scoreVec_t   scores,
	output classIndex_t classIndex,
	output logic        outValid
);

	hiddenVec_t hidden;
	logic       hiddenValid;
	scoreVec_t  scoreRaw;
	logic       scoreValid;

	////////////////////////////////////////
	// Three + three + one cycles
	////////////////////////////////////////

	hiddenLayer hiddenStage (
		.clk(clk),
		.reset(reset),
		.inputs(inputs),
		.inValid(inValid),
		.hidden(hidden),
		.hiddenValid(hiddenValid)
	);

	outputLayer outputStage (
		.clk(clk),
		.reset(reset),
		.hidden(hidden),
		.hiddenValid(hiddenValid),
		.scoreRaw(scoreRaw),
		.scoreValid(scoreValid)
	);

	classDecide decideStage (
		.clk(clk),
		.reset(reset),
		.scoreRaw(scoreRaw),
		.scoreValid(scoreValid),
		.scores(scores),
		.classIndex(classIndex),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

/* bench/nnRefModel.svh */
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

////////////////////////////////////////
// Reference model of the classifier
////////////////////////////////////////

// Keep the low byte of a full sum, then apply ReLU on its sign bit
function automatic activation_t wrapRelu(input int acc);
	logic [`NN_WIDTH-1:0] low;
	low = acc[`NN_WIDTH-1:0];
	if (low[`NN_WIDTH-1])
	begin
		return '0;
	end
	return activation_t'(low);
endfunction

function automatic hiddenVec_t hiddenActivations(input inputVec_t vec);
	activation_t feature [`NN_INPUTS];
	activation_t result [`NN_HIDDEN];
	hiddenVec_t hidden;
	int acc;
	feature = '{vec.a0, vec.a1, vec.a2, vec.a3, vec.a4,
		vec.a5, vec.a6, vec.a7, vec.a8, vec.a9};
	for (int k = 0; k < `NN_HIDDEN; k++)
	begin
		// Truncating once at the end equals truncating every product
		acc = int'(hiddenBias[k]);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			acc += int'(feature[i]) * int'(hiddenWeights[k][i]);
		end
		result[k] = wrapRelu(acc);
	end
	hidden.h0 = result[0];
	hidden.h1 = result[1];
	hidden.h2 = result[2];
	hidden.h3 = result[3];
	return hidden;
endfunction

function automatic scoreVec_t outputScores(input hiddenVec_t hidden);
	activation_t feature [`NN_HIDDEN];
	activation_t result [`NN_OUTPUTS];
	scoreVec_t scoreSet;
	int acc;
	feature = '{hidden.h0, hidden.h1, hidden.h2, hidden.h3};
	for (int k = 0; k < `NN_OUTPUTS; k++)
	begin
		acc = int'(outputBias[k]);
		for (int i = 0; i < `NN_HIDDEN; i++)
		begin
			acc += int'(feature[i]) * int'(outputWeights[k][i]);
		end
		result[k] = wrapRelu(acc);
	end
	scoreSet.s0 = result[0];
	scoreSet.s1 = result[1];
	return scoreSet;
endfunction

// Class 1 only on a strict win, ties go to class 0
function automatic classIndex_t winningClass(input scoreVec_t scoreSet);
	if (scoreSet.s1 > scoreSet.s0)
	begin
		return 1'b1;
	end
	return 1'b0;
endfunction

`endif

/* bench/nnClassifierTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nnSettings.svh"

module nnClassifierTb
	import nnPkg::*;
();

	localparam int clkPeriod = 8;
	// Cycles from driving a vector to seeing its result
	localparam int latency = 7;
	localparam int stimCount = 12;
	localparam int randomCount = 40;

	typedef struct packed
	{
		inputVec_t   vec;
		logic [7:0]  gap;
		logic        known;
		scoreVec_t   scores;
		classIndex_t cls;
	} stimRow_t;

	typedef struct packed
	{
		scoreVec_t   scores;
		classIndex_t cls;
		int          due;
		int          tag;
	} expectEntry_t;

	logic        clk = 1'b0;
	logic        reset;
	inputVec_t   inputs;
	logic        inValid;
	scoreVec_t   scores;
	classIndex_t classIndex;
	logic        outValid;

	int cycleCount = 0;
	int vectorCount = 0;
	int checkedCount = 0;
	int mismatchCount = 0;
	int protocolCount = 0;
	int seed;
	expectEntry_t expectQueue [$];

	// Vector, idle cycles after it, known flag, expected scores, expected class
	// Rows without the known flag take their expected values from the model
	stimRow_t stimTable [stimCount] = '{
		'{80'h0, 8'd2, 1'b1, '{8'sd110, 8'sd0}, 1'b0},
		'{{8'h01, 72'h0}, 8'd0, 1'b1, '{8'sd25, 8'sd48}, 1'b1},
		'{{8'hFF, 72'h0}, 8'd0, 1'b1, '{8'sd0, 8'sd96}, 1'b1},
		'{{8'hFE, 72'h0}, 8'd0, 1'b1, '{8'sd0, 8'sd0}, 1'b0},
		'{{8'h03, 72'h0}, 8'd1, 1'b1, '{8'sd0, 8'sd0}, 1'b0},
		'{{8'h04, 72'h0}, 8'd0, 1'b1, '{8'sd0, 8'sd114}, 1'b1},
		'{{8'h05, 72'h0}, 8'd3, 1'b1, '{8'sd0, 8'sd0}, 1'b0},
		'{{10{8'h7F}}, 8'd0, 1'b0, '0, 1'b0},
		'{{10{8'h80}}, 8'd0, 1'b0, '0, 1'b0},
		'{80'h0102030405060708090A, 8'd2, 1'b0, '0, 1'b0},
		'{{5{8'h80, 8'h7F}}, 8'd0, 1'b0, '0, 1'b0},
		'{80'hC35AE10977F23B964DA8, 8'd4, 1'b0, '0, 1'b0}
	};

	nnClassifier dut (
		.clk(clk),
		.reset(reset),
		.inputs(inputs),
		.inValid(inValid),
		.scores(scores),
		.classIndex(classIndex),
		.outValid(outValid)
	);

	`include "nnRefModel.svh"

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	task automatic driveVector(input inputVec_t vec, input scoreVec_t expScores,
		input classIndex_t expClass);
		expectEntry_t entry;
		inputs = vec;
		inValid = 1'b1;
		entry.scores = expScores;
		entry.cls = expClass;
		entry.due = cycleCount + latency;
		entry.tag = vectorCount;
		expectQueue.push_back(entry);
		vectorCount++;
		@(posedge clk);
		#1;
	endtask

	task automatic holdIdle(input int cycles);
		inValid = 1'b0;
		inputs = '0;
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	function automatic int idleTotal();
		int total;
		total = 0;
		for (int r = 0; r < stimCount; r++)
		begin
			total += int'(stimTable[r].gap);
		end
		return total;
	endfunction

	task automatic checkResult(input expectEntry_t entry);
		checkedCount++;
		assert (scores.s0 == entry.scores.s0)
		else
		begin
			mismatchCount++;
			$display("Mismatch at %0t: vector %0d scores.s0 got %0d expected %0d",
				$time, entry.tag, scores.s0, entry.scores.s0);
		end
		assert (scores.s1 == entry.scores.s1)
		else
		begin
			mismatchCount++;
			$display("Mismatch at %0t: vector %0d scores.s1 got %0d expected %0d",
				$time, entry.tag, scores.s1, entry.scores.s1);
		end
		assert (classIndex == entry.cls)
		else
		begin
			mismatchCount++;
			$display("Mismatch at %0t: vector %0d classIndex got %0d expected %0d",
				$time, entry.tag, classIndex, entry.cls);
		end
	endtask

	////////////////////////////////////////
	// Scoreboard sampled on the falling edge
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (reset)
		begin
			assert (!outValid && scores == '0)
			else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: outputs not cleared by reset, outValid %b scores %h",
					$time, outValid, scores);
			end
		end
		else if (outValid)
		begin
			assert (expectQueue.size() != 0 && expectQueue[0].due == cycleCount)
			else
			begin
				protocolCount++;
				$display("Error at %0t: outValid was high in cycle %0d with no result due",
					$time, cycleCount);
			end
			if (expectQueue.size() != 0 && expectQueue[0].due == cycleCount)
			begin
				checkResult(expectQueue.pop_front());
			end
		end
		else
		begin
			assert (expectQueue.size() == 0 || expectQueue[0].due > cycleCount)
			else
			begin
				protocolCount++;
				$display("Error at %0t: the result of vector %0d did not appear in cycle %0d",
					$time, expectQueue[0].tag, cycleCount);
				void'(expectQueue.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin : mainSequence
		scoreVec_t modelScores;
		classIndex_t modelClass;
		inputVec_t vec;
		logic [95:0] randomBits;
		int leftover;
		seed = 62;
		reset = 1'b1;
		inputs = '0;
		inValid = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int r = 0; r < stimCount; r++)
		begin
			modelScores = outputScores(hiddenActivations(stimTable[r].vec));
			modelClass = winningClass(modelScores);
			if (stimTable[r].known)
			begin
				assert (modelScores == stimTable[r].scores && modelClass == stimTable[r].cls)
				else
				begin
					mismatchCount++;
					$display("Mismatch at %0t: table row %0d disagrees with the reference model",
						$time, r);
				end
				driveVector(stimTable[r].vec, stimTable[r].scores, stimTable[r].cls);
			end
			else
			begin
				driveVector(stimTable[r].vec, modelScores, modelClass);
			end
			if (stimTable[r].gap != 0)
			begin
				holdIdle(int'(stimTable[r].gap));
			end
		end

		// Random vectors back to back
		for (int n = 0; n < randomCount; n++)
		begin
			randomBits = {$random(seed), $random(seed), $random(seed)};
			vec = randomBits[79:0];
			modelScores = outputScores(hiddenActivations(vec));
			driveVector(vec, modelScores, winningClass(modelScores));
		end
		inValid = 1'b0;
		inputs = '0;

		while (expectQueue.size() != 0)
		begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);

		leftover = expectQueue.size();
		$display("Checked %0d of %0d vectors: %0d mismatches, %0d protocol errors, %0d leftover",
			checkedCount, vectorCount, mismatchCount, protocolCount, leftover);
		if (mismatchCount + protocolCount + leftover == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial
	begin : watchdog
		int limitCycles;
		#1;
		limitCycles = stimCount + randomCount + idleTotal() + 20;
		#(limitCycles * clkPeriod);
		$display("Timeout: the run did not finish within %0d cycles", limitCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* nnClassifier.f */
+incdir+hdl
+incdir+bench
hdl/nnPkg.sv
hdl/neuronNode.sv
hdl/hiddenLayer.sv
hdl/outputLayer.sv
hdl/classDecide.sv
hdl/nnClassifier.sv
bench/nnClassifierTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the classifier testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found on PATH"
	exit 1
fi

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module nnClassifierTb \
	-f nnClassifier.f \
	-Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

simOutput=$(./obj_dir/VnnClassifierTb)
status=$?
echo "$simOutput"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$simOutput" | grep -qxF "Result: PASSED"; then
	exit 0
fi
exit 1
